// File: cache_perf_monitor.f
+incdir+src
src/perf_types_pkg.sv
src/sampler_types_pkg.sv
src/reuse_table.sv
src/sample_buffer.sv
src/lease_sampler.sv
src/cache_performance_controller.sv
src/cache_perf_monitor_top.sv
tests/cache_perf_monitor_tb.sv

// File: src/cache_perf_monitor_top.sv
`timescale 1ns/1ns
`default_nettype none

module cache_perf_monitor_top
	import perf_types_pkg::*;
(
	input  wire				clock_i,
	input  wire				resetn_i,
	input  wire				req_i,				// cache reference valid
	input  wire pc_t		pc_ref_i,
	input  wire tag_t		tag_ref_i,
	input  wire				hit_i,
	input  wire				miss_i,
	input  wire				writeback_i,
	input  wire word_t		comm_i,
	output word_t			comm_o,
	output logic			stall_o				// cache must hold off references
);

cache_performance_controller u_ctrl (
	.clock_i		(clock_i		),
	.resetn_i		(resetn_i		),
	.req_i			(req_i			),
	.pc_ref_i		(pc_ref_i		),
	.tag_ref_i		(tag_ref_i		),
	.hit_i			(hit_i			),
	.miss_i			(miss_i			),
	.writeback_i	(writeback_i	),
	.comm_i			(comm_i			),
	.comm_o			(comm_o			),
	.stall_o		(stall_o		)
);

endmodule

`default_nettype wire

// File: src/cache_performance_controller.sv
`timescale 1ns/1ns
`default_nettype none
`include "perf_settings.svh"

module cache_performance_controller
	import perf_types_pkg::*;
	import sampler_types_pkg::*;
(
	input  wire				clock_i,
	input  wire				resetn_i,
	input  wire				req_i,
	input  wire pc_t		pc_ref_i,
	input  wire tag_t		tag_ref_i,
	input  wire				hit_i,				// one cycle per cache hit
	input  wire				miss_i,				// one cycle per initial miss
	input  wire				writeback_i,		// one cycle per block written back
	input  wire word_t		comm_i,				// control and readout select
	output word_t			comm_o,
	output logic			stall_o
);

localparam int CNT_W = $clog2(`TABLE_DEPTH) + 1;

counter_t			hit_cnt_q;
counter_t			miss_cnt_q;
counter_t			wb_cnt_q;
word_t				comm_q;
logic				pop_bit_q;						// last comm_i pop bit
comm_sel_t			comm_sel;
logic				enable;
logic				pop;

pc_t				head_pc;
tag_t				head_tag;
counter_t			head_interval;
counter_t			head_stamp;
buf_ptr_t			used;
counter_t			ref_count;
logic [CNT_W-1:0]	remaining;
logic				buffer_full;

assign comm_sel = comm_i[3:0];
assign enable = comm_i[`COMM_ENABLE_BIT];
assign pop = comm_i[`COMM_POP_BIT] && !pop_bit_q;	// rising edge only
assign comm_o = comm_q;

// event counters
// ----------------------------------------------------------------------
always_ff @(posedge clock_i) begin
	if (!resetn_i) begin
		hit_cnt_q <= '0;
		miss_cnt_q <= '0;
		wb_cnt_q <= '0;
		pop_bit_q <= 1'b0;
	end else begin
		pop_bit_q <= comm_i[`COMM_POP_BIT];
		if (enable && hit_i) hit_cnt_q <= hit_cnt_q + 1'b1;
		if (enable && miss_i) miss_cnt_q <= miss_cnt_q + 1'b1;
		if (enable && writeback_i) wb_cnt_q <= wb_cnt_q + 1'b1;
	end
end

// readout, one cycle behind the select
// ----------------------------------------------------------------------
always_ff @(posedge clock_i) begin
	if (!resetn_i) begin
		comm_q <= '0;
	end else begin
		case (comm_sel)
			4'd0: comm_q <= hit_cnt_q[31:0];
			4'd1: comm_q <= hit_cnt_q[63:32];
			4'd2: comm_q <= miss_cnt_q[31:0];
			4'd3: comm_q <= miss_cnt_q[63:32];
			4'd4: comm_q <= wb_cnt_q[31:0];
			4'd5: comm_q <= wb_cnt_q[63:32];
			4'd6: comm_q <= head_pc;
			4'd7: comm_q <= head_interval[31:0];		// low word only
			4'd8: comm_q <= word_t'(used);
			4'd9: comm_q <= ref_count[31:0];
			4'd10: comm_q <= word_t'(remaining);
			4'd11: comm_q <= head_stamp[31:0];
			4'd12: comm_q <= head_stamp[63:32];
			4'd13: comm_q <= word_t'(head_tag);
			4'd14: comm_q <= '0;						// system id
			default: comm_q <= word_t'(buffer_full);
		endcase
	end
end

lease_sampler u_sampler (
	.clock_i			(clock_i		),
	.resetn_i			(resetn_i		),
	.enable_i			(enable			),
	.pop_i				(pop			),
	.req_i				(req_i			),
	.pc_ref_i			(pc_ref_i		),
	.tag_ref_i			(tag_ref_i		),
	.head_pc_o			(head_pc		),
	.head_tag_o			(head_tag		),
	.head_interval_o	(head_interval	),
	.head_stamp_o		(head_stamp		),
	.used_o				(used			),
	.count_o			(ref_count		),
	.remaining_o		(remaining		),
	.buffer_full_o		(buffer_full	),
	.stall_o			(stall_o		)
);

a_comm_reset: assert property (@(posedge clock_i) !resetn_i |=> (comm_o == '0));

a_cnt_monotonic: assert property (@(posedge clock_i) resetn_i |=>
	(hit_cnt_q >= $past(hit_cnt_q)) && (miss_cnt_q >= $past(miss_cnt_q)) &&
	(wb_cnt_q >= $past(wb_cnt_q)));

endmodule

`default_nettype wire

// File: src/lease_sampler.sv
`timescale 1ns/1ns
`default_nettype none
`include "perf_settings.svh"

module lease_sampler
	import perf_types_pkg::*;
	import sampler_types_pkg::*;
(
	input  wire					clock_i,
	input  wire					resetn_i,
	input  wire					enable_i,			// comm_i enable level
	input  wire					pop_i,				// one cycle pulse
	input  wire					req_i,
	input  wire pc_t			pc_ref_i,
	input  wire tag_t			tag_ref_i,
	output pc_t					head_pc_o,
	output tag_t				head_tag_o,
	output counter_t			head_interval_o,
	output counter_t			head_stamp_o,
	output buf_ptr_t			used_o,
	output counter_t			count_o,			// reference clock
	output logic [$clog2(`TABLE_DEPTH):0]	remaining_o,	// free table slots
	output logic				buffer_full_o,
	output logic				stall_o
);

sampler_state_e	state_q;
counter_t		ref_clk_q;							// enabled references seen
table_idx_t		flush_idx_q;

logic			match;
pc_t			match_pc;
counter_t		match_stamp;
logic			go;									// reference may touch the table
logic			candidate;
logic			push;
logic			alloc;
logic			flushing;
logic			flush_done;

assign flushing = (state_q == S_FLUSH);
assign flush_done = (flush_idx_q == table_idx_t'(`TABLE_DEPTH - 1));
assign candidate = (ref_clk_q[`SAMPLE_RATE_LOG2-1:0] == '0);

// back-pressure, cache holds off instead of queueing
assign stall_o = (remaining_o == '0) || buffer_full_o || flushing;
assign go = enable_i && req_i && !stall_o;
assign push = go && match;							// reuse closes the sample
assign alloc = go && !match && candidate;			// free slot guaranteed by !stall_o
assign count_o = ref_clk_q;

// ----------------------------------------------------------------------
// ref clock and flush FSM
// ----------------------------------------------------------------------
always_ff @(posedge clock_i) begin
	if (!resetn_i) begin
		state_q <= S_IDLE;
		ref_clk_q <= '0;
		flush_idx_q <= '0;
	end else begin
		if (enable_i && req_i) ref_clk_q <= ref_clk_q + 1'b1;	// stalled refs too
		case (state_q)
			S_IDLE: begin
				if (enable_i) state_q <= S_ACTIVE;
			end
			S_ACTIVE: begin
				if (!enable_i) begin
					state_q <= S_FLUSH;
					flush_idx_q <= '0;
				end
			end
			S_FLUSH: begin
				flush_idx_q <= flush_idx_q + 1'b1;			// one slot per cycle
				if (flush_done) state_q <= S_IDLE;
			end
			default: state_q <= S_IDLE;
		endcase
	end
end

reuse_table u_table (
	.clock_i		(clock_i		),
	.resetn_i		(resetn_i		),
	.lookup_tag_i	(tag_ref_i		),
	.alloc_i		(alloc			),
	.alloc_pc_i		(pc_ref_i		),
	.stamp_i		(ref_clk_q		),
	.free_i			(push			),
	.flush_i		(flushing		),
	.flush_idx_i	(flush_idx_q	),
	.match_o		(match			),
	.match_pc_o		(match_pc		),
	.match_stamp_o	(match_stamp	),
	.free_count_o	(remaining_o	)
);

sample_buffer u_buffer (
	.clock_i			(clock_i					),
	.resetn_i			(resetn_i					),
	.push_i				(push						),
	.pop_i				(pop_i						),
	.push_pc_i			(match_pc					),
	.push_tag_i			(tag_ref_i					),
	.push_interval_i	(ref_clk_q - match_stamp	),	// reuse interval
	.push_stamp_i		(ref_clk_q					),
	.head_pc_o			(head_pc_o					),
	.head_tag_o			(head_tag_o					),
	.head_interval_o	(head_interval_o			),
	.head_stamp_o		(head_stamp_o				),
	.used_o				(used_o						),
	.full_o				(buffer_full_o				)
);

// a pushed record is never dropped by a full buffer
a_no_push_full: assert property (@(posedge clock_i) disable iff (!resetn_i)
	push && !pop_i |=> used_o == $past(used_o) + 1'b1);

endmodule

`default_nettype wire

// File: src/perf_settings.svh
`ifndef PERF_SETTINGS_SVH
`define PERF_SETTINGS_SVH

// ----------------------------------------------------------------------
// cache geometry seen by the monitor
// ----------------------------------------------------------------------
`define BW_CACHE_TAG		20	// tag bits of a cache reference

// ----------------------------------------------------------------------
// reuse sampler sizing
// ----------------------------------------------------------------------
`define TABLE_DEPTH			4	// open samples tracked at once, power of two
`define BUFFER_DEPTH		8	// finished samples waiting for readout, power of two
`define SAMPLE_RATE_LOG2	1	// candidate when ref clock low bits are zero

// ----------------------------------------------------------------------
// comm_i control bits
// ----------------------------------------------------------------------
`define COMM_ENABLE_BIT		24	// level, counting and sampling on
`define COMM_POP_BIT		25	// rising edge drops the buffer head

`endif

// File: src/perf_types_pkg.sv
`default_nettype none
`include "perf_settings.svh"

// types shared between the cache side and the readout path
package perf_types_pkg;

	typedef logic [63:0] counter_t;					// event counter, ref clock, timestamps

	typedef logic [31:0] word_t;						// comm_i / comm_o word

	typedef logic [`BW_CACHE_TAG-1:0] tag_t;		// cache tag of a reference

	typedef logic [31:0] pc_t;						// pc of the referencing instruction

	// comm_i[3:0], picks the word returned on comm_o
	typedef logic [3:0] comm_sel_t;

endpackage

`default_nettype wire

// File: src/reuse_table.sv
`timescale 1ns/1ns
`default_nettype none
`include "perf_settings.svh"

module reuse_table
	import perf_types_pkg::*;
	import sampler_types_pkg::*;
(
	input  wire						clock_i,
	input  wire						resetn_i,
	input  wire tag_t				lookup_tag_i,		// tag of the current reference
	input  wire						alloc_i,			// open a sample for lookup_tag_i
	input  wire pc_t				alloc_pc_i,
	input  wire counter_t			stamp_i,			// ref clock at allocation
	input  wire						free_i,				// close the matched entry
	input  wire						flush_i,
	input  wire table_idx_t			flush_idx_i,
	output logic					match_o,
	output pc_t						match_pc_o,
	output counter_t				match_stamp_o,
	output logic [$clog2(`TABLE_DEPTH):0]	free_count_o
);

localparam int DEPTH = `TABLE_DEPTH;
localparam int CNT_W = $clog2(`TABLE_DEPTH) + 1;

logic [DEPTH-1:0]	valid_q;						// slot holds an open sample
tag_t				tag_q [DEPTH];
pc_t				pc_q [DEPTH];
counter_t			stamp_q [DEPTH];

logic [DEPTH-1:0]	hit_vec;
table_idx_t			match_idx;
table_idx_t			alloc_idx;
logic [CNT_W-1:0]	free_cnt;
logic				can_alloc;

// lookup and free slot search
// ----------------------------------------------------------------------
always_comb begin
	hit_vec = '0;
	match_idx = '0;
	alloc_idx = '0;
	free_cnt = '0;
	for (int i = DEPTH - 1; i >= 0; i--) begin		// walk down, lowest index wins
		hit_vec[i] = valid_q[i] && (tag_q[i] == lookup_tag_i);
		if (hit_vec[i]) begin
			match_idx = table_idx_t'(i);
		end
		if (!valid_q[i]) begin
			alloc_idx = table_idx_t'(i);
			free_cnt = free_cnt + 1'b1;
		end
	end
end

assign match_o = |hit_vec;
assign match_pc_o = match_o ? pc_q[match_idx] : '0;
assign match_stamp_o = match_o ? stamp_q[match_idx] : '0;
assign free_count_o = free_cnt;
assign can_alloc = alloc_i && !flush_i && (free_cnt != '0);

// slot ownership, flush has priority over the cache side
always_ff @(posedge clock_i) begin
	if (!resetn_i) begin
		valid_q <= '0;
	end else if (flush_i) begin
		valid_q[flush_idx_i] <= 1'b0;					// one slot per cycle
	end else if (free_i && match_o) begin
		valid_q[match_idx] <= 1'b0;						// sample closed by reuse
	end else if (can_alloc) begin
		valid_q[alloc_idx] <= 1'b1;
	end
end

always_ff @(posedge clock_i) begin
	if (can_alloc) begin
		tag_q[alloc_idx] <= lookup_tag_i;
		pc_q[alloc_idx] <= alloc_pc_i;
		stamp_q[alloc_idx] <= stamp_i;
	end
end

// the sampler allocates only on a miss and frees only on a hit
a_alloc_free_excl: assert property (@(posedge clock_i) disable iff (!resetn_i)
	!(alloc_i && free_i));

endmodule

`default_nettype wire

// File: src/sample_buffer.sv
`timescale 1ns/1ns
`default_nettype none
`include "perf_settings.svh"

module sample_buffer
	import perf_types_pkg::*;
	import sampler_types_pkg::*;
(
	input  wire					clock_i,
	input  wire					resetn_i,
	input  wire					push_i,
	input  wire					pop_i,				// ignored when empty
	input  wire pc_t			push_pc_i,
	input  wire tag_t			push_tag_i,
	input  wire counter_t		push_interval_i,
	input  wire counter_t		push_stamp_i,		// ref clock at sample end
	output pc_t					head_pc_o,
	output tag_t				head_tag_o,
	output counter_t			head_interval_o,
	output counter_t			head_stamp_o,
	output buf_ptr_t			used_o,
	output logic				full_o
);

localparam int DEPTH = `BUFFER_DEPTH;
localparam int IDX_W = $clog2(`BUFFER_DEPTH);

pc_t		pc_mem [DEPTH];
tag_t		tag_mem [DEPTH];
counter_t	interval_mem [DEPTH];
counter_t	stamp_mem [DEPTH];

buf_ptr_t	wr_ptr_q;
buf_ptr_t	rd_ptr_q;
logic		empty;
logic		do_push;
logic		do_pop;

assign used_o = wr_ptr_q - rd_ptr_q;				// wraps cleanly thanks to the msb
assign full_o = (used_o == buf_ptr_t'(DEPTH));
assign empty = (used_o == '0);
assign do_push = push_i && !full_o;
assign do_pop = pop_i && !empty;

always_ff @(posedge clock_i) begin
	if (!resetn_i) begin
		wr_ptr_q <= '0;
		rd_ptr_q <= '0;
	end else begin
		if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
		if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
	end
end

always_ff @(posedge clock_i) begin
	if (do_push) begin
		pc_mem[wr_ptr_q[IDX_W-1:0]] <= push_pc_i;
		tag_mem[wr_ptr_q[IDX_W-1:0]] <= push_tag_i;
		interval_mem[wr_ptr_q[IDX_W-1:0]] <= push_interval_i;
		stamp_mem[wr_ptr_q[IDX_W-1:0]] <= push_stamp_i;
	end
end

// head reads zero once drained
assign head_pc_o = empty ? '0 : pc_mem[rd_ptr_q[IDX_W-1:0]];
assign head_tag_o = empty ? '0 : tag_mem[rd_ptr_q[IDX_W-1:0]];
assign head_interval_o = empty ? '0 : interval_mem[rd_ptr_q[IDX_W-1:0]];
assign head_stamp_o = empty ? '0 : stamp_mem[rd_ptr_q[IDX_W-1:0]];

a_used_bound: assert property (@(posedge clock_i) disable iff (!resetn_i)
	used_o <= buf_ptr_t'(DEPTH));

endmodule

`default_nettype wire

// File: src/sampler_types_pkg.sv
`default_nettype none
`include "perf_settings.svh"

// types private to the reuse interval sampler
package sampler_types_pkg;

	// idle -> active on enable, active -> flush when enable drops
	typedef enum logic [1:0] {
		S_IDLE,
		S_ACTIVE,
		S_FLUSH
	} sampler_state_e;

	typedef logic [$clog2(`TABLE_DEPTH)-1:0] table_idx_t;		// reuse table slot

	// extra msb tells full from empty and doubles as occupancy
	typedef logic [$clog2(`BUFFER_DEPTH):0] buf_ptr_t;

endpackage

`default_nettype wire

// File: tests/cache_perf_monitor_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "perf_settings.svh"

module cache_perf_monitor_tb
	import perf_types_pkg::*;
;

localparam int N_IDLE = 16;							// select sweep right after reset
localparam int N_COUNT = 300;						// enabled event counting
localparam int N_QUIET = 40;						// events with enable low
localparam int N_SAMPLE = 400;						// random refs, pops, readouts
localparam int N_FILL = 120;						// no pops, buffer runs full
localparam int N_FLUSH = `TABLE_DEPTH + 4;
localparam int N_READ = 16;
localparam int N_DRAIN = 40;
localparam int RUN_CYCLES = 2 + N_IDLE + N_COUNT + N_QUIET + N_SAMPLE + N_FILL + N_FLUSH
	+ N_READ + N_DRAIN + 4;
localparam int LIMIT = RUN_CYCLES + 100;
localparam int ST_IDLE = 0;
localparam int ST_ACTIVE = 1;
localparam int ST_FLUSH = 2;

logic clock_i;
logic resetn_i;
logic req_i;
pc_t pc_ref_i;
tag_t tag_ref_i;
logic hit_i;
logic miss_i;
logic writeback_i;
word_t comm_i;
word_t comm_o;
logic stall_o;

logic [31:0] rng = 32'd51;							// xorshift state
int comm_errors = 0;
int stall_errors = 0;
int flush_errors = 0;
int cycle_count = 0;
word_t exp_comm;
logic exp_stall;

// ----------------------------------------------------------------------
// reference model state
// ----------------------------------------------------------------------
counter_t m_hit, m_miss, m_wb, m_ref_clk;
int m_state;
int m_flush_idx;
logic m_pop_prev;
logic m_valid [`TABLE_DEPTH];
tag_t m_tag [`TABLE_DEPTH];
pc_t m_pc [`TABLE_DEPTH];
counter_t m_stamp [`TABLE_DEPTH];
pc_t q_pc [$];										// buffered samples, head at 0
tag_t q_tag [$];
counter_t q_ivl [$];
counter_t q_end [$];

cache_perf_monitor_top uut (
	.clock_i		(clock_i		),
	.resetn_i		(resetn_i		),
	.req_i			(req_i			),
	.pc_ref_i		(pc_ref_i		),
	.tag_ref_i		(tag_ref_i		),
	.hit_i			(hit_i			),
	.miss_i			(miss_i			),
	.writeback_i	(writeback_i	),
	.comm_i			(comm_i			),
	.comm_o			(comm_o			),
	.stall_o		(stall_o		)
);

initial begin
	clock_i = 1'b0;
	forever #4 clock_i = ~clock_i;					// 8 ns period
end

function automatic logic [31:0] next_rand();
	rng = rng ^ (rng << 13);
	rng = rng ^ (rng >> 17);
	rng = rng ^ (rng << 5);
	return rng;
endfunction

function automatic tag_t pool_tag(input int idx);
	return tag_t'(32'h0001_2000 + idx * 32'h340);	// six tags, spread apart
endfunction

function automatic int free_entries();
	int n;
	n = 0;
	for (int i = 0; i < `TABLE_DEPTH; i++) if (!m_valid[i]) n++;
	return n;
endfunction

function automatic logic expected_stall();
	return (free_entries() == 0) || (q_pc.size() == `BUFFER_DEPTH) || (m_state == ST_FLUSH);
endfunction

// word returned one cycle after the select, from state before the edge
function automatic word_t expected_readout(input logic [3:0] sel);
	logic empty;
	empty = (q_pc.size() == 0);
	case (sel)
		4'd0: return m_hit[31:0];
		4'd1: return m_hit[63:32];
		4'd2: return m_miss[31:0];
		4'd3: return m_miss[63:32];
		4'd4: return m_wb[31:0];
		4'd5: return m_wb[63:32];
		4'd6: return empty ? '0 : q_pc[0];
		4'd7: return empty ? '0 : q_ivl[0][31:0];
		4'd8: return word_t'(q_pc.size());
		4'd9: return m_ref_clk[31:0];
		4'd10: return word_t'(free_entries());
		4'd11: return empty ? '0 : q_end[0][31:0];
		4'd12: return empty ? '0 : q_end[0][63:32];
		4'd13: return empty ? '0 : word_t'(q_tag[0]);
		4'd14: return '0;								// system id
		default: return word_t'(q_pc.size() == `BUFFER_DEPTH);
	endcase
endfunction

task automatic model_reset();
	m_hit = '0;
	m_miss = '0;
	m_wb = '0;
	m_ref_clk = '0;
	m_state = ST_IDLE;
	m_flush_idx = 0;
	m_pop_prev = 1'b0;
	for (int i = 0; i < `TABLE_DEPTH; i++) m_valid[i] = 1'b0;
	q_pc.delete();
	q_tag.delete();
	q_ivl.delete();
	q_end.delete();
endtask

// one clock edge of the monitor, inputs as sampled at that edge
task automatic model_step();
	logic en, pop, go;
	int midx, fidx;
	en = comm_i[`COMM_ENABLE_BIT];
	pop = comm_i[`COMM_POP_BIT] && !m_pop_prev;		// rising edge of the pop bit
	go = en && req_i && !expected_stall();
	midx = -1;
	fidx = -1;
	for (int i = 0; i < `TABLE_DEPTH; i++) begin
		if (midx < 0 && m_valid[i] && m_tag[i] == tag_ref_i) midx = i;
		if (fidx < 0 && !m_valid[i]) fidx = i;		// lowest free slot
	end
	if (pop && q_pc.size() > 0) begin				// empty pop is a no-op
		void'(q_pc.pop_front());
		void'(q_tag.pop_front());
		void'(q_ivl.pop_front());
		void'(q_end.pop_front());
	end
	if (m_state == ST_FLUSH) begin
		m_valid[m_flush_idx] = 1'b0;
	end else if (go && midx >= 0) begin			// reuse completes the sample
		q_pc.push_back(m_pc[midx]);
		q_tag.push_back(tag_ref_i);
		q_ivl.push_back(m_ref_clk - m_stamp[midx]);
		q_end.push_back(m_ref_clk);
		m_valid[midx] = 1'b0;
	end else if (go && (m_ref_clk % (64'd1 << `SAMPLE_RATE_LOG2)) == 0 && fidx >= 0) begin
		m_valid[fidx] = 1'b1;
		m_tag[fidx] = tag_ref_i;
		m_pc[fidx] = pc_ref_i;
		m_stamp[fidx] = m_ref_clk;
	end
	if (en && hit_i) m_hit++;
	if (en && miss_i) m_miss++;
	if (en && writeback_i) m_wb++;
	if (en && req_i) m_ref_clk++;					// stalled refs count too
	case (m_state)
		ST_IDLE: if (en) m_state = ST_ACTIVE;
		ST_ACTIVE: begin
			if (!en) begin
				m_state = ST_FLUSH;
				m_flush_idx = 0;
			end
		end
		default: begin
			if (m_flush_idx == `TABLE_DEPTH - 1) m_state = ST_IDLE;
			m_flush_idx++;
		end
	endcase
	m_pop_prev = comm_i[`COMM_POP_BIT];
endtask

// ----------------------------------------------------------------------
// compare DUT against the model, mid cycle
// ----------------------------------------------------------------------
always @(posedge clock_i) begin
	if (!resetn_i) begin
		model_reset();
		exp_comm = '0;
	end else begin
		exp_comm = expected_readout(comm_i[3:0]);
		model_step();
	end
	exp_stall = expected_stall();
	#3;
	assert (comm_o === exp_comm) else begin
		comm_errors++;
		$display("Fail comm_o: expected %h got %h", exp_comm, comm_o);
	end
	assert (stall_o === exp_stall) else begin
		stall_errors++;
		$display("Fail stall_o: expected %h got %h", exp_stall, stall_o);
	end
end

task automatic drive_cycle(input logic req, input int tag_idx, input logic hit,
	input logic miss, input logic wb, input logic [3:0] sel, input logic en, input logic popb);
	@(posedge clock_i);
	#1;
	req_i = req;
	tag_ref_i = pool_tag(tag_idx);
	pc_ref_i = next_rand();
	hit_i = hit;
	miss_i = miss;
	writeback_i = wb;
	comm_i = '0;
	comm_i[3:0] = sel;
	comm_i[`COMM_ENABLE_BIT] = en;
	comm_i[`COMM_POP_BIT] = popb;
endtask

// sel is already 10 with the flush done, next edge latches the free count
task automatic check_flush_result();
	@(posedge clock_i);
	#3;
	assert (comm_o == word_t'(`TABLE_DEPTH)) else begin
		flush_errors++;
		$display("Fail comm_o free count after flush: expected %h got %h",
			word_t'(`TABLE_DEPTH), comm_o);
	end
endtask

initial begin
	while (cycle_count < LIMIT) begin
		@(posedge clock_i);
		cycle_count++;
	end
	$display("timeout: the test did not finish within %0d cycles", LIMIT);
	$display("Test failed");
	$finish;
end

initial begin
	logic [31:0] r;
	resetn_i = 1'b0;
	req_i = 1'b0;
	pc_ref_i = '0;
	tag_ref_i = '0;
	hit_i = 1'b0;
	miss_i = 1'b0;
	writeback_i = 1'b0;
	comm_i = '0;
	repeat (2) @(posedge clock_i);
	#1 resetn_i = 1'b1;
	for (int i = 0; i < N_IDLE; i++) drive_cycle(0, 0, 0, 0, 0, i[3:0], 0, 0);	// all zero
	for (int i = 0; i < N_COUNT; i++) begin
		r = next_rand();
		drive_cycle(0, 0, r[8], r[9], r[10], 4'(r[31:16] % 6), 1, 0);
	end
	for (int i = 0; i < N_QUIET; i++) begin		// counters must hold
		r = next_rand();
		drive_cycle(0, 0, r[8], r[9], r[10], 4'(r[31:16] % 6), 0, 0);
	end
	for (int i = 0; i < N_SAMPLE; i++) begin
		r = next_rand();
		drive_cycle(r[1:0] != 2'b00, (r >> 8) % 6, r[21], r[22], r[23], r[15:12], 1, r[20]);
	end
	for (int i = 0; i < N_FILL; i++) begin			// no pops, stall expected
		r = next_rand();
		drive_cycle(1, (r >> 8) % 6, r[21], r[22], r[23], r[15:12], 1, 0);
	end
	for (int i = 0; i < N_FLUSH; i++) begin
		r = next_rand();
		drive_cycle(r[0], (r >> 8) % 6, 0, 0, 0, 4'd10, 0, 0);
	end
	check_flush_result();
	for (int i = 0; i < N_READ; i++) drive_cycle(0, 0, 0, 0, 0, i[3:0], 0, 0);	// samples kept
	for (int i = 0; i < N_DRAIN; i++) begin		// pop on every other cycle
		r = next_rand();
		drive_cycle(0, 0, 0, 0, 0, r[15:12], 0, i[0]);
	end
	repeat (2) @(posedge clock_i);
	#4;
	$display("errors: comm_o %0d, stall_o %0d, flush %0d", comm_errors, stall_errors,
		flush_errors);
	if (comm_errors + stall_errors + flush_errors == 0) begin
		$display("Test passed");
	end else begin
		$display("Test failed");
	end
	$finish;
end

endmodule

`default_nettype wire
